// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = packet_switch_tb
FLIST = vlog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== hw/egress_crossbar.sv ====
module egress_crossbar (
    input  logic                             clk,
    input  logic                             rst_n,
    input  packet_pkg::packet_t              head [packet_pkg::num_ports],
    input  logic [packet_pkg::num_ports-1:0] out_active,
    input  packet_pkg::port_sel_t            out_sel [packet_pkg::num_ports],
    output logic [packet_pkg::num_ports-1:0] out_valid,
    output packet_pkg::packet_t              out_data [packet_pkg::num_ports]
);

    import packet_pkg::*;

    // ==============================
    // Output registers
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= out_active;
        end
    end

    // Data only loads on a transfer and keeps its last word otherwise
    always_ff @(posedge clk) begin
        for (int o = 0; o < num_ports; o++) begin
            if (out_active[o]) begin
                out_data[o] <= head[out_sel[o]];
            end
        end
    end

    // The delivered packet must actually name this output in its mask,
    // otherwise the select pointed at a port that was not sending here
    for (genvar o = 0; o < num_ports; o++) begin : g_out_chk
        dst_mask_t data_mask;

        assign data_mask = pkt_mask(out_data[o]);

        a_valid_used_sel: assert property (
            @(posedge clk) disable iff (!rst_n)
            out_valid[o] |-> data_mask[o]
        ) else $error("egress_crossbar: output %0d valid with data %h", o, out_data[o]);
    end

endmodule

// ==== hw/packet_fifo.sv ====
module packet_fifo #(
    parameter int depth = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  packet_pkg::packet_t wr_data,
    input  logic                rd_en,
    output packet_pkg::packet_t rd_data,
    output logic                full,
    output logic                empty
);

    import packet_pkg::*;

    localparam int aw = $clog2(depth);
    localparam logic [aw:0] full_count = (aw + 1)'(depth);

    packet_t       mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_wr;
    logic          do_rd;

    // Requests against a full or empty buffer are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == full_count);
    assign empty = (count == '0);

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head word is always visible, popping just moves the pointer
    assign rd_data = mem[rd_ptr];

    a_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rd_en && empty)
    ) else $error("packet_fifo: read while empty");

    // A word written into an empty buffer is the head on the next cycle
    a_header_coherent: assert property (
        @(posedge clk) disable iff (!rst_n)
        (do_wr && empty) |=> (pkt_header(rd_data) == $past(pkt_header(wr_data)))
    ) else $error("packet_fifo: head header %h wrong after a write into an empty FIFO",
                  pkt_header(rd_data));

endmodule

// ==== hw/packet_pkg.sv ====
package packet_pkg;

    // ==============================
    // Switch geometry
    // ==============================

    // Fixed port count, both ingress and egress
    localparam int unsigned num_ports = 4;

    // ==============================
    // Packet word and its fields
    // ==============================

    // One packet word, header in the low byte and payload in the high byte
    typedef logic [15:0] packet_t;

    // Header byte, tag in bits 7:4 and destination mask in bits 3:0
    typedef logic [7:0] header_t;

    // One bit per egress port
    typedef logic [3:0] dst_mask_t;

    // Index of an ingress or egress port
    typedef logic [1:0] port_sel_t;

    // Master to slave side of a Wishbone classic write
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        packet_t dat;
    } wb_req_t;

    // Per-port request machine
    typedef enum logic [1:0] {
        idle     = 2'd0,
        request  = 2'd1,
        transmit = 2'd2
    } state_t;

    function automatic header_t pkt_header(packet_t pkt);
        return pkt[7:0];
    endfunction

    function automatic dst_mask_t pkt_mask(packet_t pkt);
        return pkt[3:0];
    endfunction

endpackage

// ==== hw/packet_switch_top.sv ====
module packet_switch_top #(
    parameter int depth = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  packet_pkg::wb_req_t              wb [packet_pkg::num_ports],
    output logic [packet_pkg::num_ports-1:0] ack,
    output logic [packet_pkg::num_ports-1:0] out_valid,
    output packet_pkg::packet_t              out_data [packet_pkg::num_ports]
);

    import packet_pkg::*;

    logic [num_ports-1:0] req;
    logic [num_ports-1:0] grant;
    logic [num_ports-1:0] out_active;
    dst_mask_t            req_mask [num_ports];
    packet_t              head [num_ports];
    port_sel_t            out_sel [num_ports];

    // ==============================
    // Ingress ports
    // ==============================

    for (genvar i = 0; i < num_ports; i++) begin : g_port
        switch_port #(
            .depth(depth)
        ) port_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .wb      (wb[i]),
            .grant   (grant[i]),
            .ack     (ack[i]),
            .req     (req[i]),
            .req_mask(req_mask[i]),
            .head    (head[i])
        );
    end

    // ==============================
    // Arbitration and egress
    // ==============================

    switch_arbiter arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_mask  (req_mask),
        .grant     (grant),
        .out_active(out_active),
        .out_sel   (out_sel)
    );

    // Head words go straight from the ports, selected by the arbiter
    egress_crossbar crossbar_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .out_active(out_active),
        .out_sel   (out_sel),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== hw/switch_arbiter.sv ====
module switch_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [packet_pkg::num_ports-1:0]      req,
    input  packet_pkg::dst_mask_t                 req_mask [packet_pkg::num_ports],
    output logic [packet_pkg::num_ports-1:0]      grant,
    output logic [packet_pkg::num_ports-1:0]      out_active,
    output packet_pkg::port_sel_t                 out_sel [packet_pkg::num_ports]
);

    import packet_pkg::*;

    port_sel_t common_ptr;

    // ==============================
    // Rotating priority pointer
    // ==============================

    // Free-running, so priority moves on whether or not anyone requests
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            common_ptr <= '0;
        end else begin
            common_ptr <= common_ptr + 1'b1;
        end
    end

    // ==============================
    // Grant resolution
    // ==============================

    // Walk the ports from the pointer, a port wins only if none of its
    // outputs was taken by an earlier winner in the same cycle
    always_comb begin
        dst_mask_t claimed;
        port_sel_t p;

        claimed    = '0;
        p          = '0;
        grant      = '0;
        out_active = '0;
        for (int o = 0; o < num_ports; o++) begin
            out_sel[o] = '0;
        end

        for (int i = 0; i < num_ports; i++) begin
            p = common_ptr + port_sel_t'(i);
            if (req[p] && ((req_mask[p] & claimed) == '0)) begin
                grant[p] = 1'b1;
                claimed  = claimed | req_mask[p];
                // One grant drives every output in the mask
                for (int o = 0; o < num_ports; o++) begin
                    if (req_mask[p][o]) begin
                        out_active[o] = 1'b1;
                        out_sel[o]    = p;
                    end
                end
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_ptr_rotates: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (common_ptr != $past(common_ptr))
    ) else $error("switch_arbiter: common_ptr stuck at %0d", common_ptr);

    for (genvar p = 0; p < num_ports; p++) begin : g_port_chk
        for (genvar o = 0; o < num_ports; o++) begin : g_out_chk
            // Granted multicast must own every output it asked for
            a_coherence: assert property (
                @(posedge clk) disable iff (!rst_n)
                (grant[p] && req_mask[p][o]) |->
                    (out_active[o] && out_sel[o] == port_sel_t'(p))
            ) else $error("switch_arbiter: port %0d granted, output %0d sel %0d active %b",
                          p, o, out_sel[o], out_active[o]);
        end
    end

endmodule

// ==== hw/switch_port.sv ====
module switch_port #(
    parameter int depth = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  packet_pkg::wb_req_t   wb,
    input  logic                  grant,
    output logic                  ack,
    output logic                  req,
    output packet_pkg::dst_mask_t req_mask,
    output packet_pkg::packet_t   head
);

    import packet_pkg::*;

    state_t state;
    logic   wr_en;
    logic   rd_en;
    logic   full;
    logic   empty;
    logic   zero_mask;

    // ==============================
    // Wishbone ingress
    // ==============================

    // One-cycle ack, then at least one idle cycle before the next one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= !ack && wb.cyc && wb.stb && wb.we && !full;
        end
    end

    // Master holds the word until it sees ack, so it is taken on the ack edge
    assign wr_en = ack;

    packet_fifo #(
        .depth(depth)
    ) fifo_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_data(wb.dat),
        .rd_en  (rd_en),
        .rd_data(head),
        .full   (full),
        .empty  (empty)
    );

    // ==============================
    // Request machine
    // ==============================

    assign req_mask  = pkt_mask(head);
    assign zero_mask = (req_mask == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (!empty) begin
                        state <= request;
                    end
                end
                request: begin
                    // Zero mask goes straight to the pop and is dropped
                    if (zero_mask || grant) begin
                        state <= transmit;
                    end
                end
                transmit: state <= idle;
                default:  state <= idle;
            endcase
        end
    end

    assign req   = (state == request) && !zero_mask;
    assign rd_en = (state == transmit);

    a_state_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        empty |-> (state == idle || state == transmit)
    ) else $error("switch_port: state %s with empty FIFO", state.name());

endmodule

// ==== verif/packet_switch_tb.sv ====
module packet_switch_tb;

    import packet_pkg::*;

    // One table row: phase, ingress port, destination mask, packet count
    typedef struct packed {
        logic [1:0] phase;
        port_sel_t  port;
        dst_mask_t  mask;
        logic [3:0] reps;
    } row_t;

    localparam int n_rows   = 33;
    localparam int n_queues = num_ports * num_ports;
    // out_valid shows up in the fourth cycle, counting the ack cycle as the first
    localparam int iso_latency = 3;
    localparam int ack_limit   = 200;
    localparam int drain_limit = 2000;

    // ==============================
    // Stimulus table
    // ==============================

    localparam row_t rows [n_rows] = '{
        // Phase 0, one packet at a time, unicast then multicast
        '{2'd0, 2'd0, 4'h1, 4'd1}, '{2'd0, 2'd0, 4'h2, 4'd1}, '{2'd0, 2'd0, 4'h4, 4'd1},
        '{2'd0, 2'd0, 4'h8, 4'd1}, '{2'd0, 2'd1, 4'h1, 4'd1}, '{2'd0, 2'd1, 4'h2, 4'd1},
        '{2'd0, 2'd1, 4'h4, 4'd1}, '{2'd0, 2'd1, 4'h8, 4'd1}, '{2'd0, 2'd2, 4'h1, 4'd1},
        '{2'd0, 2'd2, 4'h2, 4'd1}, '{2'd0, 2'd2, 4'h4, 4'd1}, '{2'd0, 2'd2, 4'h8, 4'd1},
        '{2'd0, 2'd3, 4'h1, 4'd1}, '{2'd0, 2'd3, 4'h2, 4'd1}, '{2'd0, 2'd3, 4'h4, 4'd1},
        '{2'd0, 2'd3, 4'h8, 4'd1}, '{2'd0, 2'd0, 4'h3, 4'd1}, '{2'd0, 2'd1, 4'hc, 4'd1},
        '{2'd0, 2'd2, 4'hf, 4'd1}, '{2'd0, 2'd3, 4'h5, 4'd1},
        // Phase 1, all four ports aim at output 2
        '{2'd1, 2'd0, 4'h4, 4'd3}, '{2'd1, 2'd1, 4'h4, 4'd3}, '{2'd1, 2'd2, 4'h4, 4'd3},
        '{2'd1, 2'd3, 4'h4, 4'd3},
        // Phase 2, two bursts of twelve broadcasts into port 0 against busy neighbours,
        // more than a port can drain at one packet every three cycles
        '{2'd2, 2'd0, 4'hf, 4'd12}, '{2'd2, 2'd0, 4'hf, 4'd12}, '{2'd2, 2'd1, 4'h1, 4'd6},
        '{2'd2, 2'd2, 4'h2, 4'd6}, '{2'd2, 2'd3, 4'h8, 4'd6},
        // Phase 3, zero mask followed by a real packet
        '{2'd3, 2'd2, 4'h0, 4'd1}, '{2'd3, 2'd2, 4'h8, 4'd1}, '{2'd3, 2'd1, 4'h0, 4'd1},
        '{2'd3, 2'd1, 4'h3, 4'd1}
    };

    logic                 clk;
    logic                 rst_n;
    wb_req_t              wb [num_ports];
    logic [num_ports-1:0] ack;
    logic [num_ports-1:0] out_valid;
    packet_t              out_data [num_ports];

    // Scoreboard, one queue per output and source, index output * 4 + source
    packet_t exp_q [n_queues][$];
    int      exp_cyc [n_queues][$];
    int      errors;
    int      checked;
    int      stalls;
    int      cycle;
    int      seed;
    bit      isolated;

    packet_switch_top #(
        .depth(8)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .ack      (ack),
        .out_valid(out_valid),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < n_queues; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    task automatic check_idle();
        if (ack !== 4'h0) begin
            errors++;
            $display("Fail ack: got %h expected %h", ack, 4'h0);
        end
        if (out_valid !== 4'h0) begin
            errors++;
            $display("Fail out_valid: got %h expected %h", out_valid, 4'h0);
        end
    endtask

    // Wishbone classic write, word held until the ack edge has passed
    task automatic wb_write(input int port, input packet_t pkt);
        int waited;
        waited = 0;
        wb[port] = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: pkt};
        do begin
            @(negedge clk);
            waited++;
        end while (!ack[port] && waited < ack_limit);
        if (!ack[port]) begin
            errors++;
            $display("Port %0d never acknowledged a write within %0d cycles", port, waited);
        end else begin
            if (waited > 1) begin
                stalls++;
            end
            for (int o = 0; o < num_ports; o++) begin
                if (pkt[o]) begin
                    exp_q[o * num_ports + port].push_back(pkt);
                    exp_cyc[o * num_ports + port].push_back(cycle);
                end
            end
        end
        @(negedge clk);
        wb[port] = '{cyc: 1'b0, stb: 1'b0, we: 1'b0, dat: pkt};
    endtask

    task automatic send_row(input int r);
        packet_t pkt;
        for (int k = 0; k < int'(rows[r].reps); k++) begin
            // Tag carries the source port so the monitor can find the queue
            pkt = {8'($random(seed)), 4'(rows[r].port), rows[r].mask};
            wb_write(int'(rows[r].port), pkt);
        end
    endtask

    task automatic send_phase(input int ph, input int port);
        for (int r = 0; r < n_rows; r++) begin
            if (int'(rows[r].phase) == ph && int'(rows[r].port) == port) begin
                send_row(r);
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (pending() != 0) begin
            errors++;
            $display("Drain ran out of time with %0d packets never delivered", pending());
        end
        // Quiet stretch so stray copies still get caught
        repeat (8) @(negedge clk);
    endtask

    // ==============================
    // Output monitor
    // ==============================

    task automatic check_output(input int o);
        int      q;
        int      lat;
        packet_t want;
        q = o * num_ports + int'(out_data[o][5:4]);
        checked++;
        if (out_data[o][7:6] != 2'b00 || exp_q[q].size() == 0) begin
            errors++;
            $display("Unexpected packet %h on output %0d", out_data[o], o);
        end else begin
            want = exp_q[q].pop_front();
            lat  = cycle - exp_cyc[q].pop_front();
            if (out_data[o] !== want) begin
                errors++;
                $display("Fail out_data[%0d]: got %h expected %h", o, out_data[o], want);
            end
            if (isolated && lat != iso_latency) begin
                errors++;
                $display("Packet %h on output %0d came %0d cycles after ack instead of %0d",
                         want, o, lat, iso_latency);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            for (int o = 0; o < num_ports; o++) begin
                if (out_valid[o]) begin
                    check_output(o);
                end
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rst_n    = 1'b0;
        seed     = 32'h8740;
        errors   = 0;
        checked  = 0;
        stalls   = 0;
        cycle    = 0;
        isolated = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            wb[p] = '0;
        end

        // Two reset cycles, then quiet cycles before the first write
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        isolated = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            if (rows[r].phase == 2'd0) begin
                send_row(r);
                drain();
            end
        end
        isolated = 1'b0;

        for (int ph = 1; ph < 4; ph++) begin
            stalls = 0;
            fork
                send_phase(ph, 0);
                send_phase(ph, 1);
                send_phase(ph, 2);
                send_phase(ph, 3);
            join
            drain();
            $display("Phase %0d done, %0d writes waited for FIFO space", ph, stalls);
            // The port 0 burst overruns its FIFO, so ack has to hold off
            if (ph == 2 && stalls == 0) begin
                errors++;
                $display("Port 0 burst never saw ack stall on a full FIFO");
            end
        end

        $display("%0d packets checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/packet_pkg.sv
hw/packet_fifo.sv
hw/switch_port.sv
hw/switch_arbiter.sv
hw/egress_crossbar.sv
hw/packet_switch_top.sv
verif/packet_switch_tb.sv
